// ==== flist.f ====
hw/frv_pkg.sv
hw/frv_mmio_axil.sv
hw/frv_counters.sv
hw/frv_interrupt.sv
hw/frv_uncore.sv
+incdir+verif
verif/tb_frv_uncore.sv

// ==== hw/frv_counters.sv ====
// --------------------------------------------------------------------------
// Machine counters and timer
// Keeps time, cycle and instret, holds mtimecmp and decodes the MMIO
// register window, raising the timer interrupt on compare
// --------------------------------------------------------------------------
module frv_counters import frv_pkg::*; #(
  parameter xlen_t MMIO_BASE_ADDR = 32'h0000_1000, // Register window base
  parameter xlen_t MMIO_BASE_MASK = 32'hFFFF_F000  // Window size mask
) (
  input  logic  g_clk,                         // Global clock
  input  logic  rst,                           // Sync reset, active high

  input  logic  instr_ret,                     // Instruction retired
  input  logic  inhibit_cy,                    // Freeze cycle
  input  logic  inhibit_tm,                    // Freeze time
  input  logic  inhibit_ir,                    // Freeze instret

  output ctr_t  ctr_time,
  output ctr_t  ctr_cycle,
  output ctr_t  ctr_instret,
  output logic  timer_interrupt,               // Registered compare result

  input  logic  mmio_en,                       // Access strobe
  input  logic  mmio_wen,
  input  xlen_t mmio_addr,
  input  xlen_t mmio_wdata,
  output xlen_t mmio_rdata,                    // Combinational answer
  output logic  mmio_error
);

  ctr_t  mtimecmp;                             // Timer compare value
  xlen_t reg_off;                              // Offset inside window
  logic  in_range;                             // Address inside window
  logic  reg_hit;                              // Offset names a register
  logic  reg_ro;                               // Register is read only
  xlen_t rd_val;
  logic  wr_ok;                                // Accepted write this cycle

  // ------------------------------------------------------------------------
  // Address decode

  assign in_range = (mmio_addr & MMIO_BASE_MASK) == MMIO_BASE_ADDR;
  assign reg_off  = mmio_addr & ~MMIO_BASE_MASK;

  always_comb begin
    reg_hit = 1'b1;
    reg_ro  = 1'b0;
    rd_val  = '0;
    case (reg_off)
      REG_MTIME_LO:    rd_val = ctr_time[31:0];
      REG_MTIME_HI:    rd_val = ctr_time[63:32];
      REG_MTIMECMP_LO: rd_val = mtimecmp[31:0];
      REG_MTIMECMP_HI: rd_val = mtimecmp[63:32];
      REG_CYCLE_LO: begin
        rd_val = ctr_cycle[31:0];
        reg_ro = 1'b1;
      end
      REG_INSTRET_LO: begin
        rd_val = ctr_instret[31:0];
        reg_ro = 1'b1;
      end
      default:         reg_hit = 1'b0;     // Hole in the map
    endcase
    if (!in_range || (mmio_wen && reg_ro)) rd_val = '0;  // Nothing to return
  end

  assign mmio_error = mmio_en && (!in_range || !reg_hit || (mmio_wen && reg_ro));
  assign mmio_rdata = rd_val;
  assign wr_ok      = mmio_en && mmio_wen && !mmio_error;

  // ------------------------------------------------------------------------
  // Counters

  always_ff @(posedge g_clk) begin
    if (rst) begin
      ctr_time <= '0;
    end else if (wr_ok && reg_off == REG_MTIME_LO) begin
      ctr_time <= {ctr_time[63:32], mmio_wdata};  // Write beats increment
    end else if (wr_ok && reg_off == REG_MTIME_HI) begin
      ctr_time <= {mmio_wdata, ctr_time[31:0]};
    end else if (!inhibit_tm) begin
      ctr_time <= ctr_time + 64'd1;
    end
  end

  always_ff @(posedge g_clk) begin
    if (rst) begin
      ctr_cycle   <= '0;
      ctr_instret <= '0;
    end else begin
      if (!inhibit_cy)             ctr_cycle   <= ctr_cycle + 64'd1;
      if (instr_ret && !inhibit_ir) ctr_instret <= ctr_instret + 64'd1;
    end
  end

  // All ones keeps the timer quiet out of reset
  always_ff @(posedge g_clk) begin
    if (rst) begin
      mtimecmp <= '1;
    end else if (wr_ok && reg_off == REG_MTIMECMP_LO) begin
      mtimecmp[31:0] <= mmio_wdata;
    end else if (wr_ok && reg_off == REG_MTIMECMP_HI) begin
      mtimecmp[63:32] <= mmio_wdata;
    end
  end

  always_ff @(posedge g_clk) begin
    if (rst) timer_interrupt <= 1'b0;
    else     timer_interrupt <= ctr_time >= mtimecmp;  // One cycle late
  end

  // Error responses never leak register contents
  a_err_zero : assert property (@(posedge g_clk) disable iff (rst)
    mmio_error |-> mmio_rdata == '0);

endmodule

// ==== hw/frv_interrupt.sv ====
// --------------------------------------------------------------------------
// Interrupt controller
// Registers pending lines, picks one by priority and enables, and holds a
// trap request with its cause until the pipeline acknowledges it
// --------------------------------------------------------------------------
module frv_interrupt import frv_pkg::*; (
  input  logic       g_clk,                    // Global clock
  input  logic       rst,                      // Sync reset, active high

  input  logic       mstatus_mie,              // Global enable
  input  logic       mie_meie,                 // External enable
  input  logic       mie_mtie,                 // Timer enable
  input  logic       mie_msie,                 // Software enable

  input  logic       nmi_pending,              // Raw request lines
  input  logic       ex_pending,
  input  logic [3:0] ex_cause,                 // External cause code
  input  logic       ti_pending,
  input  logic       sw_pending,

  output logic       mip_meip,                 // Registered pending bits
  output logic       mip_mtip,
  output logic       mip_msip,

  output logic       int_trap_req,             // Trap request to pipeline
  output cause_t     int_trap_cause,           // Held while req is high
  input  logic       int_trap_ack              // Pipeline takes the trap
);

  logic       nmi_q;                           // Registered NMI line
  logic [3:0] ex_cause_q;
  logic       take_nmi;
  logic       take_ext;
  logic       take_sw;
  logic       take_tim;
  logic       any_take;
  cause_t     win_cause;                       // Highest priority cause

  always_ff @(posedge g_clk) begin
    if (rst) begin
      nmi_q    <= 1'b0;
      mip_meip <= 1'b0;
      mip_mtip <= 1'b0;
      mip_msip <= 1'b0;
    end else begin
      nmi_q    <= nmi_pending;
      mip_meip <= ex_pending;
      mip_mtip <= ti_pending;
      mip_msip <= sw_pending;
    end
  end

  always_ff @(posedge g_clk) ex_cause_q <= ex_cause;  // Aligned with mip_meip

  // ------------------------------------------------------------------------
  // Priority select

  assign take_nmi = nmi_q;                     // Ignores every enable
  assign take_ext = mstatus_mie && mie_meie && mip_meip;
  assign take_sw  = mstatus_mie && mie_msie && mip_msip;
  assign take_tim = mstatus_mie && mie_mtie && mip_mtip;
  assign any_take = take_nmi || take_ext || take_sw || take_tim;

  always_comb begin
    if (take_nmi)      win_cause = CAUSE_NMI;
    else if (take_ext) win_cause = CAUSE_MEI_BASE + cause_t'(ex_cause_q);
    else if (take_sw)  win_cause = CAUSE_MSI;
    else               win_cause = CAUSE_MTI;
  end

  // ------------------------------------------------------------------------
  // Request / acknowledge

  always_ff @(posedge g_clk) begin
    if (rst)                                int_trap_req <= 1'b0;
    else if (int_trap_req && int_trap_ack)  int_trap_req <= 1'b0;  // Drop after ack
    else if (!int_trap_req && any_take)     int_trap_req <= 1'b1;
  end

  always_ff @(posedge g_clk) begin
    if (!int_trap_req && any_take) int_trap_cause <= win_cause;  // Latch on rise
  end

  // Cause frozen for as long as the pipeline withholds ack
  a_cause_stable : assert property (@(posedge g_clk) disable iff (rst)
    int_trap_req && !int_trap_ack |=> int_trap_req && $stable(int_trap_cause));

endmodule

// ==== hw/frv_mmio_axil.sv ====
// --------------------------------------------------------------------------
// AXI4-Lite slave to MMIO strobe adapter
// Takes one transaction at a time and issues a single cycle MMIO access,
// then returns the captured data and status on the B or R channel
// --------------------------------------------------------------------------
module frv_mmio_axil import frv_pkg::*; (
  input  logic      g_clk,                     // Global clock
  input  logic      rst,                       // Sync reset, active high

  input  logic      s_awvalid,                 // Write address channel
  output logic      s_awready,
  input  xlen_t     s_awaddr,
  input  logic      s_wvalid,                  // Write data channel
  output logic      s_wready,
  input  xlen_t     s_wdata,
  input  logic [3:0] s_wstrb,                  // Ignored, full words only
  output logic      s_bvalid,                  // Write response channel
  input  logic      s_bready,
  output axi_resp_t s_bresp,
  input  logic      s_arvalid,                 // Read address channel
  output logic      s_arready,
  input  xlen_t     s_araddr,
  output logic      s_rvalid,                  // Read data channel
  input  logic      s_rready,
  output xlen_t     s_rdata,
  output axi_resp_t s_rresp,

  output logic      mmio_en,                   // One cycle access strobe
  output logic      mmio_wen,                  // Strobe is a write
  output xlen_t     mmio_addr,
  output xlen_t     mmio_wdata,
  input  xlen_t     mmio_rdata,                // Same cycle answer
  input  logic      mmio_error
);

  typedef enum logic [1:0] {
    ST_IDLE,                                   // Waiting for address
    ST_ACCESS,                                 // MMIO strobe cycle
    ST_WRESP,                                  // Holding B until bready
    ST_RRESP                                   // Holding R until rready
  } axil_state_t;

  axil_state_t state;
  logic        rd_accept;                      // AR handshake this cycle
  logic        wr_accept;                      // AW and W handshake
  logic        acc_wen;                        // Latched direction
  xlen_t       acc_addr;
  xlen_t       acc_wdata;
  axi_resp_t   acc_resp;

  // Reads win over writes arriving together
  assign rd_accept = (state == ST_IDLE) && s_arvalid;
  assign wr_accept = (state == ST_IDLE) && !s_arvalid && s_awvalid && s_wvalid;

  assign s_arready = rd_accept;
  assign s_awready = wr_accept;                // AW and W taken together
  assign s_wready  = wr_accept;

  assign mmio_en    = (state == ST_ACCESS);
  assign mmio_wen   = mmio_en && acc_wen;
  assign mmio_addr  = acc_addr;
  assign mmio_wdata = acc_wdata;

  assign s_bvalid = (state == ST_WRESP);
  assign s_rvalid = (state == ST_RRESP);
  assign s_bresp  = acc_resp;                  // One status register serves both
  assign s_rresp  = acc_resp;

  always_ff @(posedge g_clk) begin
    if (rst) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE:   if (rd_accept || wr_accept) state <= ST_ACCESS;
        ST_ACCESS: state <= acc_wen ? ST_WRESP : ST_RRESP;
        ST_WRESP:  if (s_bready) state <= ST_IDLE;
        ST_RRESP:  if (s_rready) state <= ST_IDLE;
        default:   state <= ST_IDLE;
      endcase
    end
  end

  // Address, data and response capture
  always_ff @(posedge g_clk) begin
    if (rd_accept) begin
      acc_addr <= s_araddr;
      acc_wen  <= 1'b0;
    end else if (wr_accept) begin
      acc_addr  <= s_awaddr;
      acc_wdata <= s_wdata;
      acc_wen   <= 1'b1;
    end
    if (mmio_en) begin
      s_rdata  <= mmio_rdata;                  // Already zero on error
      acc_resp <= mmio_error ? RESP_SLVERR : RESP_OKAY;
    end
  end

  // Strobe lasts exactly one cycle per transaction
  a_strobe_single : assert property (@(posedge g_clk) disable iff (rst)
    mmio_en |=> !mmio_en);

endmodule

// ==== hw/frv_pkg.sv ====
// --------------------------------------------------------------------------
// Uncore shared definitions
// Vector types, MMIO register offsets, trap causes and AXI response codes
// --------------------------------------------------------------------------
package frv_pkg;

  typedef logic [31:0] xlen_t;                 // Bus and MMIO data word
  typedef logic [63:0] ctr_t;                  // Full width counter
  typedef logic [ 5:0] cause_t;                // Trap cause code
  typedef logic [ 1:0] axi_resp_t;             // AXI response field

  // ------------------------------------------------------------------------
  // Trap causes

  localparam cause_t CAUSE_NMI      = 6'd0;    // Non-maskable
  localparam cause_t CAUSE_MSI      = 6'd3;    // Machine software
  localparam cause_t CAUSE_MTI      = 6'd7;    // Machine timer
  localparam cause_t CAUSE_MEI_BASE = 6'd16;   // Plus external cause code

  // ------------------------------------------------------------------------
  // AXI responses

  localparam axi_resp_t RESP_OKAY   = 2'd0;
  localparam axi_resp_t RESP_SLVERR = 2'd2;

  // ------------------------------------------------------------------------
  // Register byte offsets from the MMIO base

  localparam xlen_t REG_MTIME_LO    = 32'h00;
  localparam xlen_t REG_MTIME_HI    = 32'h04;
  localparam xlen_t REG_MTIMECMP_LO = 32'h08;
  localparam xlen_t REG_MTIMECMP_HI = 32'h0C;
  localparam xlen_t REG_CYCLE_LO    = 32'h10;  // Read only
  localparam xlen_t REG_INSTRET_LO  = 32'h14;  // Read only

endpackage

// ==== hw/frv_uncore.sv ====
// --------------------------------------------------------------------------
// Machine mode uncore
// AXI4-Lite register port, counters/timer and interrupt controller
// --------------------------------------------------------------------------
module frv_uncore import frv_pkg::*; #(
  parameter xlen_t MMIO_BASE_ADDR = 32'h0000_1000, // Register window base
  parameter xlen_t MMIO_BASE_MASK = 32'hFFFF_F000  // Window size mask
) (
  input  logic       g_clk,                    // Global clock
  input  logic       rst,                      // Sync reset, active high

  input  logic       s_awvalid,                // AXI4-Lite slave port
  output logic       s_awready,
  input  xlen_t      s_awaddr,
  input  logic       s_wvalid,
  output logic       s_wready,
  input  xlen_t      s_wdata,
  input  logic [3:0] s_wstrb,
  output logic       s_bvalid,
  input  logic       s_bready,
  output axi_resp_t  s_bresp,
  input  logic       s_arvalid,
  output logic       s_arready,
  input  xlen_t      s_araddr,
  output logic       s_rvalid,
  input  logic       s_rready,
  output xlen_t      s_rdata,
  output axi_resp_t  s_rresp,

  input  logic       instr_ret,                // From the pipeline
  input  logic       inhibit_cy,
  input  logic       inhibit_tm,
  input  logic       inhibit_ir,
  output ctr_t       ctr_time,
  output ctr_t       ctr_cycle,
  output ctr_t       ctr_instret,

  input  logic       int_nmi,                  // External interrupt lines
  input  logic       int_external,
  input  logic [3:0] int_extern_cause,
  input  logic       int_software,
  output logic       int_mtime,                // Timer pending

  input  logic       mstatus_mie,              // Enables from CSRs
  input  logic       mie_meie,
  input  logic       mie_mtie,
  input  logic       mie_msie,
  output logic       mip_meip,
  output logic       mip_mtip,
  output logic       mip_msip,

  output logic       int_trap_req,             // Trap handshake
  output cause_t     int_trap_cause,
  input  logic       int_trap_ack
);

  logic  mmio_en;                              // Adapter to counters
  logic  mmio_wen;
  xlen_t mmio_addr;
  xlen_t mmio_wdata;
  xlen_t mmio_rdata;
  logic  mmio_error;
  logic  timer_interrupt;                      // Counters to interrupts

  assign int_mtime = mip_mtip;

  frv_mmio_axil i_mmio_axil (.*);

  frv_counters #(
    .MMIO_BASE_ADDR (MMIO_BASE_ADDR),
    .MMIO_BASE_MASK (MMIO_BASE_MASK)
  ) i_counters (.*);

  frv_interrupt i_interrupt (
    .g_clk          (g_clk           ),
    .rst            (rst             ),
    .mstatus_mie    (mstatus_mie     ),
    .mie_meie       (mie_meie        ),
    .mie_mtie       (mie_mtie        ),
    .mie_msie       (mie_msie        ),
    .nmi_pending    (int_nmi         ),
    .ex_pending     (int_external    ),
    .ex_cause       (int_extern_cause),
    .ti_pending     (timer_interrupt ),  // Registered compare
    .sw_pending     (int_software    ),
    .mip_meip       (mip_meip        ),
    .mip_mtip       (mip_mtip        ),
    .mip_msip       (mip_msip        ),
    .int_trap_req   (int_trap_req    ),
    .int_trap_cause (int_trap_cause  ),
    .int_trap_ack   (int_trap_ack    )
  );

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the uncore testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --assert --timescale 1ns/100ps \
  -f flist.f --top-module tb_frv_uncore -Mdir obj_dir \
  && ./obj_dir/Vtb_frv_uncore | tee sim.log \
  || { echo "run_sim: build or simulation error"; exit 1; }

grep -qx "Verification passed" sim.log \
  && echo "run_sim: PASS" \
  || { echo "run_sim: FAIL"; exit 1; }

// ==== verif/tb_frv_uncore_tasks.svh ====
// --------------------------------------------------------------------------
// Uncore testbench tasks
// AXI4-Lite driver, typed compare tasks and the directed tests
// --------------------------------------------------------------------------
`ifndef TB_FRV_UNCORE_TASKS_SVH
`define TB_FRV_UNCORE_TASKS_SVH

task automatic report_mismatch(input string name, input string exp, input string act);
  errors++;
  $display("FAIL %0t %s expected %s actual %s", $time, name, exp, act);
endtask

task automatic check_word(input string name, input xlen_t exp, input xlen_t act);
  checks++;
  if (act !== exp) report_mismatch(name, $sformatf("%h", exp), $sformatf("%h", act));
endtask

task automatic check_ctr(input string name, input ctr_t exp, input ctr_t act);
  checks++;
  if (act !== exp) report_mismatch(name, $sformatf("%h", exp), $sformatf("%h", act));
endtask

task automatic check_cause(input string name, input cause_t exp, input cause_t act);
  checks++;
  if (act !== exp) report_mismatch(name, $sformatf("%0d", exp), $sformatf("%0d", act));
endtask

task automatic check_resp(input string name, input axi_resp_t exp, input axi_resp_t act);
  checks++;
  if (act !== exp) report_mismatch(name, $sformatf("%0d", exp), $sformatf("%0d", act));
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
  checks++;
  if (act !== exp) report_mismatch(name, $sformatf("%b", exp), $sformatf("%b", act));
endtask

task automatic end_test(input string name, input int errs_before);
  tests++;
  if (errors == errs_before) $display("test %s: ok", name);
  else $display("test %s: %0d errors", name, errors - errs_before);
endtask

// --------------------------------------------------------------------------
// AXI4-Lite driver

task automatic axil_write(input xlen_t addr, input xlen_t data, output axi_resp_t resp);
  @(posedge g_clk);
  s_awvalid <= 1'b1;
  s_awaddr  <= addr;
  s_wvalid  <= 1'b1;
  s_wdata   <= data;
  s_bready  <= 1'b1;
  @(negedge g_clk);
  while (!(s_awready && s_wready)) @(negedge g_clk);
  @(posedge g_clk);                              // AW and W taken here
  s_awvalid <= 1'b0;
  s_wvalid  <= 1'b0;
  @(negedge g_clk);
  while (!s_bvalid) @(negedge g_clk);
  resp = s_bresp;
  @(posedge g_clk);                              // B taken here
  s_bready <= 1'b0;
endtask

task automatic axil_read(input xlen_t addr, output xlen_t data, output axi_resp_t resp);
  @(posedge g_clk);
  s_arvalid <= 1'b1;
  s_araddr  <= addr;
  s_rready  <= 1'b1;
  @(negedge g_clk);
  while (!s_arready) @(negedge g_clk);
  @(posedge g_clk);                              // AR taken here
  s_arvalid <= 1'b0;
  @(negedge g_clk);
  while (!s_rvalid) @(negedge g_clk);
  data = s_rdata;
  resp = s_rresp;
  @(posedge g_clk);
  s_rready <= 1'b0;
endtask

// Waits for a trap request level at the falling edge
task automatic wait_req(input logic level, input int limit);
  int n;
  n = 0;
  @(negedge g_clk);
  while (int_trap_req !== level && n < limit) begin
    @(negedge g_clk);
    n++;
  end
  if (int_trap_req !== level) begin
    errors++;
    $display("At %0t int_trap_req did not go to %b within %0d cycles", $time, level, limit);
  end
endtask

task automatic ack_trap();
  @(posedge g_clk);
  int_trap_ack <= 1'b1;
  @(posedge g_clk);
  int_trap_ack <= 1'b0;
endtask

// --------------------------------------------------------------------------
// Directed tests

task automatic reg_access_test();
  int        errs;
  xlen_t     mt_hi;
  xlen_t     cmp_lo;
  xlen_t     cmp_hi;
  xlen_t     rd;
  xlen_t     lo_before;
  xlen_t     lo_after;
  axi_resp_t resp;
  errs   = errors;
  mt_hi  = $random(seed);
  cmp_lo = $random(seed);
  cmp_hi = $random(seed);
  @(negedge g_clk);
  lo_before = ctr_time[31:0];
  axil_write(BASE + REG_MTIME_HI, mt_hi, resp);
  check_resp("s_bresp", RESP_OKAY, resp);
  axil_write(BASE + REG_MTIMECMP_LO, cmp_lo, resp);
  check_resp("s_bresp", RESP_OKAY, resp);
  axil_write(BASE + REG_MTIMECMP_HI, cmp_hi, resp);
  check_resp("s_bresp", RESP_OKAY, resp);
  axil_read(BASE + REG_MTIME_HI, rd, resp);
  check_resp("s_rresp", RESP_OKAY, resp);
  @(negedge g_clk);
  lo_after = ctr_time[31:0];
  check_word("mtime_hi", (lo_after < lo_before) ? mt_hi + 32'd1 : mt_hi, rd);  // Carry
  axil_read(BASE + REG_MTIMECMP_LO, rd, resp);
  check_resp("s_rresp", RESP_OKAY, resp);
  check_word("mtimecmp_lo", cmp_lo, rd);
  axil_read(BASE + REG_MTIMECMP_HI, rd, resp);
  check_resp("s_rresp", RESP_OKAY, resp);
  check_word("mtimecmp_hi", cmp_hi, rd);
  end_test("register access", errs);
endtask

task automatic bus_error_test();
  int        errs;
  xlen_t     rd;
  axi_resp_t resp;
  errs = errors;
  axil_read(32'h0000_2000, rd, resp);            // Outside the window
  check_resp("s_rresp", RESP_SLVERR, resp);
  check_word("s_rdata", 32'h0, rd);
  axil_write(BASE + REG_CYCLE_LO, 32'h1234_5678, resp);
  check_resp("s_bresp", RESP_SLVERR, resp);
  axil_read(BASE + 32'h18, rd, resp);            // Hole in the map
  check_resp("s_rresp", RESP_SLVERR, resp);
  check_word("s_rdata", 32'h0, rd);
  end_test("bus errors", errs);
endtask

task automatic counter_test();
  int    errs;
  ctr_t  ir_start;
  ctr_t  n_ret;
  ctr_t  gap_start;
  xlen_t pattern;
  errs    = errors;
  n_ret   = '0;
  pattern = $random(seed);
  @(negedge g_clk);
  ir_start = ctr_instret;
  for (int i = 0; i < 16; i++) begin             // Counted retires
    @(posedge g_clk);
    instr_ret <= pattern[i];
    if (pattern[i]) n_ret = n_ret + 64'd1;
  end
  repeat (8) begin                               // Retires under inhibit
    @(posedge g_clk);
    instr_ret  <= 1'b1;
    inhibit_ir <= 1'b1;
  end
  @(posedge g_clk);
  instr_ret  <= 1'b0;
  inhibit_ir <= 1'b0;
  @(negedge g_clk);
  check_ctr("ctr_instret", ir_start + n_ret, ctr_instret);
  gap_start = ctr_time - ctr_cycle;
  @(posedge g_clk);
  inhibit_cy <= 1'b1;
  repeat (12) @(posedge g_clk);                  // Cycle frozen while time runs
  inhibit_cy <= 1'b0;
  @(negedge g_clk);
  check_ctr("ctr_time - ctr_cycle", gap_start + 64'd12, ctr_time - ctr_cycle);
  end_test("counters", errs);
endtask

task automatic timer_test();
  int        errs;
  ctr_t      target;
  logic      seen_high;
  axi_resp_t resp;
  errs      = errors;
  seen_high = 1'b0;
  axil_write(BASE + REG_MTIMECMP_LO, 32'hFFFF_FFFF, resp);  // Park low half high
  @(negedge g_clk);
  target = ctr_time + 64'd20;
  axil_write(BASE + REG_MTIMECMP_HI, target[63:32], resp);
  axil_write(BASE + REG_MTIMECMP_LO, target[31:0], resp);
  check_resp("s_bresp", RESP_OKAY, resp);
  repeat (2) @(negedge g_clk);                   // New compare settles
  for (int i = 0; i < 30; i++) begin
    // Pending two cycles behind the compare
    check_flag("mip_mtip", ctr_time >= target + 64'd2, mip_mtip);
    check_flag("int_mtime", ctr_time >= target + 64'd2, int_mtime);
    if (mip_mtip) seen_high = 1'b1;
    @(negedge g_clk);
  end
  check_flag("mip_mtip seen high", 1'b1, seen_high);
  @(posedge g_clk);
  mstatus_mie <= 1'b1;
  mie_mtie    <= 1'b1;
  wait_req(1'b1, 10);
  check_cause("int_trap_cause", 6'd7, int_trap_cause);
  @(posedge g_clk);
  mstatus_mie <= 1'b0;
  mie_mtie    <= 1'b0;
  ack_trap();
  axil_write(BASE + REG_MTIMECMP_HI, 32'hFFFF_FFFF, resp);  // Quiet timer again
  axil_write(BASE + REG_MTIMECMP_LO, 32'hFFFF_FFFF, resp);
  repeat (2) @(negedge g_clk);
  check_flag("mip_mtip", 1'b0, mip_mtip);
  end_test("timer interrupt", errs);
endtask

task automatic priority_test();
  int errs;
  errs = errors;
  @(posedge g_clk);
  mstatus_mie      <= 1'b1;
  mie_meie         <= 1'b1;
  mie_msie         <= 1'b1;
  mie_mtie         <= 1'b1;
  int_nmi          <= 1'b1;
  int_external     <= 1'b1;
  int_extern_cause <= 4'd5;
  int_software     <= 1'b1;
  wait_req(1'b1, 10);
  check_cause("int_trap_cause", 6'd0, int_trap_cause);
  check_flag("mip_meip", 1'b1, mip_meip);
  repeat (4) begin                               // Ack withheld
    @(negedge g_clk);
    check_flag("int_trap_req", 1'b1, int_trap_req);
    check_cause("int_trap_cause", 6'd0, int_trap_cause);
  end
  @(posedge g_clk);
  int_nmi <= 1'b0;
  @(posedge g_clk);
  ack_trap();
  wait_req(1'b0, 4);
  wait_req(1'b1, 4);
  check_cause("int_trap_cause", 6'd21, int_trap_cause);  // External with cause 5
  @(posedge g_clk);
  int_external <= 1'b0;
  @(posedge g_clk);
  ack_trap();
  wait_req(1'b0, 4);
  wait_req(1'b1, 4);
  check_cause("int_trap_cause", 6'd3, int_trap_cause);
  check_flag("mip_meip", 1'b0, mip_meip);
  @(posedge g_clk);
  int_software <= 1'b0;
  @(posedge g_clk);
  ack_trap();
  repeat (4) begin                               // Nothing left pending
    @(negedge g_clk);
    check_flag("int_trap_req", 1'b0, int_trap_req);
  end
  @(posedge g_clk);
  mstatus_mie <= 1'b0;
  mie_meie    <= 1'b0;
  mie_msie    <= 1'b0;
  mie_mtie    <= 1'b0;
  end_test("priority and handshake", errs);
endtask

task automatic enable_test();
  int errs;
  errs = errors;
  @(posedge g_clk);
  mstatus_mie  <= 1'b0;                          // Global enable off
  mie_msie     <= 1'b1;
  int_software <= 1'b1;
  repeat (2) @(negedge g_clk);
  check_flag("mip_msip", 1'b1, mip_msip);
  repeat (20) begin
    @(negedge g_clk);
    check_flag("int_trap_req", 1'b0, int_trap_req);
  end
  @(posedge g_clk);
  int_software <= 1'b0;
  mie_msie     <= 1'b0;
  end_test("enables", errs);
endtask

`endif

// ==== verif/tb_frv_uncore.sv ====
// --------------------------------------------------------------------------
// Uncore testbench
// Stands in for the pipeline, drives the AXI4-Lite port and runs the
// directed register, counter, timer and interrupt tests
// --------------------------------------------------------------------------
module tb_frv_uncore import frv_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam xlen_t BASE        = 32'h0000_1000;   // MMIO window base
  localparam xlen_t MASK        = 32'hFFFF_F000;
  localparam int    TEST_CYCLES = 500;             // Rough sum of all tests
  localparam int    CYCLE_LIMIT = 4 * TEST_CYCLES;

  logic       g_clk;
  logic       rst;
  logic       s_awvalid;                         // AXI4-Lite master side
  logic       s_awready;
  xlen_t      s_awaddr;
  logic       s_wvalid;
  logic       s_wready;
  xlen_t      s_wdata;
  logic [3:0] s_wstrb;
  logic       s_bvalid;
  logic       s_bready;
  axi_resp_t  s_bresp;
  logic       s_arvalid;
  logic       s_arready;
  xlen_t      s_araddr;
  logic       s_rvalid;
  logic       s_rready;
  xlen_t      s_rdata;
  axi_resp_t  s_rresp;
  logic       instr_ret;                         // Pipeline stand-in
  logic       inhibit_cy;
  logic       inhibit_tm;
  logic       inhibit_ir;
  ctr_t       ctr_time;
  ctr_t       ctr_cycle;
  ctr_t       ctr_instret;
  logic       int_nmi;                           // Interrupt sources
  logic       int_external;
  logic [3:0] int_extern_cause;
  logic       int_software;
  logic       int_mtime;
  logic       mstatus_mie;                       // CSR enables
  logic       mie_meie;
  logic       mie_mtie;
  logic       mie_msie;
  logic       mip_meip;
  logic       mip_mtip;
  logic       mip_msip;
  logic       int_trap_req;                      // Trap handshake
  cause_t     int_trap_cause;
  logic       int_trap_ack;

  integer seed      = 32'h6a36_bc8e;
  int     errors    = 0;
  int     checks    = 0;
  int     tests     = 0;
  int     cycle_cnt = 0;

  `include "tb_frv_uncore_tasks.svh"

  frv_uncore #(
    .MMIO_BASE_ADDR (BASE),
    .MMIO_BASE_MASK (MASK)
  ) DUT (.*);

  initial begin
    g_clk = 1'b0;
    forever #4 g_clk = ~g_clk;                   // 8 ns period
  end

  // Watchdog
  initial begin
    while (cycle_cnt < CYCLE_LIMIT) begin
      @(posedge g_clk);
      cycle_cnt++;
    end
    $display("Timeout, the tests were still running after %0d cycles", CYCLE_LIMIT);
    $display("Verification failed");
    $finish;
  end

  initial begin
    rst              = 1'b1;
    s_awvalid        = 1'b0;
    s_awaddr         = '0;
    s_wvalid         = 1'b0;
    s_wdata          = '0;
    s_wstrb          = 4'hF;                     // Full words only
    s_bready         = 1'b0;
    s_arvalid        = 1'b0;
    s_araddr         = '0;
    s_rready         = 1'b0;
    instr_ret        = 1'b0;
    inhibit_cy       = 1'b0;
    inhibit_tm       = 1'b0;
    inhibit_ir       = 1'b0;
    int_nmi          = 1'b0;
    int_external     = 1'b0;
    int_extern_cause = 4'd0;
    int_software     = 1'b0;
    mstatus_mie      = 1'b0;
    mie_meie         = 1'b0;
    mie_mtie         = 1'b0;
    mie_msie         = 1'b0;
    int_trap_ack     = 1'b0;
    repeat (2) @(posedge g_clk);                 // Two reset cycles
    rst <= 1'b0;

    reg_access_test();
    bus_error_test();
    counter_test();
    timer_test();
    priority_test();
    enable_test();

    $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule
